/* dbg_params.svh */
/*
  Widths, field positions and opcodes of the Wishbone debug module.
  The data register layout is fixed at 53 bits and all bursts are 32-bit.
*/
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Sizes
`define DBG_DR_WIDTH     53
`define DBG_ADDR_WIDTH   32
`define DBG_DATA_WIDTH   32
`define DBG_COUNT_WIDTH  16
`define DBG_WORD_BYTES   4      // Address step per burst word

// Command fields in the data register
`define DBG_OP_MSB       51
`define DBG_OP_LSB       48
`define DBG_ADDR_MSB     47     // Address runs down to bit 16

// Serial CRC-32, reflected form
`define DBG_CRC_POLY     32'hEDB88320
`define DBG_CRC_INIT     32'hFFFFFFFF

// Opcodes
`define DBG_CMD_BWRITE32 4'd3
`define DBG_CMD_BREAD32  4'd7
`define DBG_CMD_IREG_WR  4'd9
`define DBG_CMD_IREG_SEL 4'd13

`endif

/* dbg_pkg.sv */
/*
  Enumerated types shared by the debug module.
  Opcode encodings follow the params header.
*/
`default_nettype none

`include "dbg_params.svh"

package dbg_pkg;

  // Burst control states
  typedef enum logic [3:0] {
    st_idle,
    st_rbegin,
    st_rready,
    st_rstatus,
    st_rburst,
    st_rcrc,
    st_wready,
    st_wwait,
    st_wburst,
    st_wcrc,
    st_wmatch
  } dbg_state_e;

  // Module commands, bits 51..48 of the data register
  typedef enum logic [3:0] {
    cmd_bwrite32 = `DBG_CMD_BWRITE32,
    cmd_bread32  = `DBG_CMD_BREAD32,
    cmd_ireg_wr  = `DBG_CMD_IREG_WR,
    cmd_ireg_sel = `DBG_CMD_IREG_SEL
  } dbg_cmd_e;

  // Source of module_tdo_o
  typedef enum logic [1:0] {
    tdo_ready,   // BIU ready, status bit of a read
    tdo_data,    // Output shift register LSB
    tdo_match,   // Write CRC compare result
    tdo_crc      // CRC shifted out after a read
  } tdo_sel_e;

endpackage

`default_nettype wire

/* dbg_crc32.sv */
/*
  Serial CRC-32, LSB first, reflected polynomial, no final inversion.
  The register doubles as its own output shifter: shift_i moves it out at bit 0.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_params.svh"

module dbg_crc32 (
  input  wire        tck_i,
  input  wire        rst_i,
  input  wire        clr_i,     // Back to init value
  input  wire        en_i,      // Absorb bit_i
  input  wire        shift_i,   // Shift value out, zero fill
  input  wire        bit_i,
  output wire [31:0] crc_o,
  output wire        serial_o
);

  logic [31:0] crc_q;
  logic        fb;       // Feedback bit

  assign fb = crc_q[0] ^ bit_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (clr_i) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (en_i) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ ({32{fb}} & `DBG_CRC_POLY);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[31:1]};
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];   // Next bit on tdo during rcrc

endmodule

`default_nettype wire

/* dbg_wb_biu.sv */
/*
  Wishbone classic master, one 32-bit word per strobe, no sel/cti/bte.
  A strobe that arrives while a cycle is open is ignored; the caller flags it.
  The bus runs on tck_i.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_params.svh"

module dbg_wb_biu (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  wire                        clr_i,      // Clears sticky error
  input  wire                        strobe_i,   // Latch request, start cycle
  input  wire                        rd_i,       // 1 = read, 0 = write
  input  wire [`DBG_ADDR_WIDTH-1:0]  addr_i,
  input  wire [`DBG_DATA_WIDTH-1:0]  data_i,
  output logic [`DBG_DATA_WIDTH-1:0] data_o,     // Last read data
  output logic                       rdy_o,
  output logic                       err_o,
  output logic [`DBG_ADDR_WIDTH-1:0] wb_adr_o,
  output logic [`DBG_DATA_WIDTH-1:0] wb_dat_o,
  input  wire  [`DBG_DATA_WIDTH-1:0] wb_dat_i,
  output logic                       wb_cyc_o,
  output wire                        wb_stb_o,
  output logic                       wb_we_o,
  input  wire                        wb_ack_i,
  input  wire                        wb_err_i
);

  logic start;   // Request accepted this cycle
  logic done;    // Slave terminated the cycle

  assign start    = strobe_i && !wb_cyc_o;
  assign done     = wb_cyc_o && (wb_ack_i || wb_err_i);
  assign wb_stb_o = wb_cyc_o;   // Single transfer per cycle

  // Request and response payload
  always_ff @(posedge tck_i) begin
    if (start) begin
      wb_adr_o <= addr_i;
      wb_dat_o <= data_i;
    end
    if (wb_cyc_o && wb_ack_i && !wb_we_o) begin
      data_o <= wb_dat_i;   // Read data on ack only
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wb_cyc_o <= 1'b0;
      wb_we_o  <= 1'b0;
      rdy_o    <= 1'b1;   // Idle BIU reads as ready
      err_o    <= 1'b0;
    end else begin
      if (start) begin
        wb_cyc_o <= 1'b1;
        wb_we_o  <= !rd_i;
        rdy_o    <= 1'b0;
      end else if (done) begin
        wb_cyc_o <= 1'b0;   // Drops the cycle after ack/err
        wb_we_o  <= 1'b0;
        rdy_o    <= 1'b1;
      end
      // New error wins over a clear in the same cycle
      err_o <= (err_o && !clr_i) || (done && wb_err_i);
    end
  end

  // Slave may only terminate an open cycle
  a_resp_in_cycle: assert property (@(posedge tck_i) disable iff (rst_i)
    (wb_ack_i || wb_err_i) |-> wb_cyc_o);

  a_ack_err: assert property (@(posedge tck_i) disable iff (rst_i)
    !(wb_ack_i && wb_err_i));

endmodule

`default_nettype wire

/* dbg_burst_fsm.sv */
/*
  Command decode and burst control for the debug bus module.
  High-speed only: no per-word status during writes.
  The host is expected to shift continuously inside a burst.
*/
`timescale 1ns/1ps
`default_nettype none

module dbg_burst_fsm (
  input  wire                     tck_i,
  input  wire                     rst_i,
  input  wire                     capture_dr_i,
  input  wire                     shift_dr_i,
  input  wire                     update_dr_i,
  input  wire                     module_select_i,
  input  wire                     dr_top_i,          // Bit 52, 0 = module command
  input  wire dbg_pkg::dbg_cmd_e  opcode_i,
  input  wire                     word_count_zero_i,
  input  wire                     last_word_i,       // Word count is 1
  input  wire                     bit_count_last_i,  // 32nd bit of a word
  input  wire                     bit_count_32_i,
  input  wire                     biu_ready_i,
  output logic                    addr_ld_o,
  output logic                    addr_inc_o,
  output logic                    word_ld_o,
  output logic                    word_dec_o,
  output logic                    bit_clr_o,
  output logic                    bit_inc_o,
  output logic                    out_ld_bus_o,
  output logic                    out_ld_ireg_o,
  output logic                    out_shift_o,
  output logic                    crc_clr_o,
  output logic                    crc_en_o,
  output logic                    crc_in_tdi_o,      // 1 = tdi, 0 = read data
  output logic                    crc_shift_o,
  output logic                    regsel_ld_o,
  output logic                    ireg_wr_o,
  output logic                    err_check_o,
  output logic                    biu_strobe_o,
  output logic                    biu_clr_o,
  output logic                    burst_rd_o,        // BIU direction
  output dbg_pkg::tdo_sel_e       tdo_sel_o,
  output logic                    top_inhibit_o
);

  dbg_pkg::dbg_state_e state_q, state_d;
  logic module_cmd;   // Update is for this module
  logic load_word;    // Read word into output register

  assign module_cmd = module_select_i && !dr_top_i && update_dr_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_pkg::st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    load_word     = 1'b0;
    addr_ld_o     = 1'b0;
    addr_inc_o    = 1'b0;
    word_ld_o     = 1'b0;
    word_dec_o    = 1'b0;
    bit_clr_o     = 1'b0;
    bit_inc_o     = 1'b0;
    out_ld_bus_o  = 1'b0;
    out_ld_ireg_o = 1'b0;
    out_shift_o   = 1'b0;
    crc_clr_o     = 1'b0;
    crc_en_o      = 1'b0;
    crc_in_tdi_o  = 1'b0;
    crc_shift_o   = 1'b0;
    regsel_ld_o   = 1'b0;
    ireg_wr_o     = 1'b0;
    err_check_o   = 1'b0;
    biu_strobe_o  = 1'b0;
    biu_clr_o     = 1'b0;
    tdo_sel_o     = dbg_pkg::tdo_data;
    unique case (state_q)
      dbg_pkg::st_idle: begin
        // Internal register access stays in idle
        out_ld_ireg_o = module_select_i && capture_dr_i;
        out_shift_o   = module_select_i && shift_dr_i;
        regsel_ld_o   = module_cmd && (opcode_i inside {dbg_pkg::cmd_ireg_sel,
                                                        dbg_pkg::cmd_ireg_wr});
        ireg_wr_o     = module_cmd && (opcode_i == dbg_pkg::cmd_ireg_wr);
        if (module_cmd && (opcode_i inside {dbg_pkg::cmd_bread32,
                                            dbg_pkg::cmd_bwrite32})) begin
          state_d   = (opcode_i == dbg_pkg::cmd_bread32) ? dbg_pkg::st_rbegin
                                                         : dbg_pkg::st_wready;
          addr_ld_o = 1'b1;
          word_ld_o = 1'b1;
          bit_clr_o = 1'b1;
          crc_clr_o = 1'b1;
          biu_clr_o = 1'b1;   // Drop an error left by the previous burst
        end
      end
      dbg_pkg::st_rbegin: begin
        if (word_count_zero_i) begin
          state_d = dbg_pkg::st_idle;   // Empty burst
        end else begin
          state_d      = dbg_pkg::st_rready;
          biu_strobe_o = 1'b1;   // First read
          addr_inc_o   = 1'b1;
        end
      end
      dbg_pkg::st_rready: begin
        if (module_select_i && capture_dr_i) state_d = dbg_pkg::st_rstatus;
      end
      dbg_pkg::st_rstatus: begin
        tdo_sel_o = dbg_pkg::tdo_ready;   // Host polls for a 1
        if (update_dr_i) begin
          state_d = dbg_pkg::st_idle;
        end else if (shift_dr_i && biu_ready_i) begin
          state_d   = dbg_pkg::st_rburst;
          load_word = 1'b1;
        end
      end
      dbg_pkg::st_rburst: begin
        if (update_dr_i) begin
          state_d = dbg_pkg::st_idle;
        end else if (shift_dr_i) begin
          out_shift_o = 1'b1;
          bit_inc_o   = 1'b1;
          crc_en_o    = 1'b1;   // CRC sees the bit on tdo
          if (bit_count_last_i && word_count_zero_i) begin
            state_d = dbg_pkg::st_rcrc;
          end else if (bit_count_last_i) begin
            load_word = 1'b1;
          end
        end
      end
      dbg_pkg::st_rcrc: begin
        tdo_sel_o   = dbg_pkg::tdo_crc;
        crc_shift_o = shift_dr_i;
        if (update_dr_i) state_d = dbg_pkg::st_idle;
      end
      dbg_pkg::st_wready: begin
        if (word_count_zero_i) begin
          state_d = dbg_pkg::st_idle;
        end else if (module_select_i && capture_dr_i) begin
          state_d = dbg_pkg::st_wwait;
        end
      end
      dbg_pkg::st_wwait: begin
        if (update_dr_i) begin
          state_d = dbg_pkg::st_idle;
        end else if (module_select_i && shift_dr_i && dr_top_i) begin
          // Start bit in; tdi already holds data bit 0
          state_d      = dbg_pkg::st_wburst;
          bit_inc_o    = 1'b1;
          word_dec_o   = 1'b1;
          crc_en_o     = 1'b1;
          crc_in_tdi_o = 1'b1;
        end
      end
      dbg_pkg::st_wburst: begin
        if (update_dr_i) begin
          state_d = dbg_pkg::st_idle;   // Host aborted
        end else if (shift_dr_i) begin
          bit_inc_o    = 1'b1;
          crc_en_o     = 1'b1;
          crc_in_tdi_o = 1'b1;
          if (bit_count_last_i) begin
            bit_clr_o    = 1'b1;
            biu_strobe_o = 1'b1;   // Word complete with tdi
            addr_inc_o   = 1'b1;
            err_check_o  = 1'b1;
            word_dec_o   = !word_count_zero_i;
            if (word_count_zero_i) state_d = dbg_pkg::st_wcrc;
          end
        end
      end
      dbg_pkg::st_wcrc: begin
        if (update_dr_i) begin
          state_d = dbg_pkg::st_idle;
        end else if (bit_count_32_i) begin
          state_d   = dbg_pkg::st_wmatch;
          tdo_sel_o = dbg_pkg::tdo_match;   // Host CRC now fully in DR
        end else begin
          bit_inc_o = shift_dr_i;
        end
      end
      dbg_pkg::st_wmatch: begin
        tdo_sel_o   = dbg_pkg::tdo_match;
        err_check_o = update_dr_i;   // Last write has had time to finish
        if (update_dr_i) state_d = dbg_pkg::st_idle;
      end
      default: state_d = dbg_pkg::st_idle;
    endcase
    // Shared word load of a read burst
    if (load_word) begin
      out_ld_bus_o = 1'b1;
      bit_clr_o    = 1'b1;
      word_dec_o   = 1'b1;
      err_check_o  = 1'b1;
      biu_strobe_o = !last_word_i;   // Prefetch next word
      addr_inc_o   = !last_word_i;
    end
  end

  assign top_inhibit_o = state_q inside {dbg_pkg::st_rstatus, dbg_pkg::st_rburst,
                                         dbg_pkg::st_rcrc, dbg_pkg::st_wwait,
                                         dbg_pkg::st_wburst, dbg_pkg::st_wcrc,
                                         dbg_pkg::st_wmatch};
  assign burst_rd_o    = state_q inside {dbg_pkg::st_rbegin, dbg_pkg::st_rready,
                                         dbg_pkg::st_rstatus, dbg_pkg::st_rburst,
                                         dbg_pkg::st_rcrc};

  a_state_legal: assert property (@(posedge tck_i) disable iff (rst_i)
    state_q inside {[dbg_pkg::st_idle:dbg_pkg::st_wmatch]});

endmodule

`default_nettype wire

/* dbg_wb_datapath.sv */
/*
  Counters, output shifter, error register, CRC and tdo select of the debug module.
  Only register index 0 (bus error) exists; other indices read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_params.svh"

module dbg_wb_datapath (
  input  wire                         tck_i,
  input  wire                         rst_i,
  input  wire                         tdi_i,
  input  wire  [`DBG_DR_WIDTH-1:0]    dr_i,
  input  wire                         addr_ld_i,
  input  wire                         addr_inc_i,
  input  wire                         word_ld_i,
  input  wire                         word_dec_i,
  input  wire                         bit_clr_i,
  input  wire                         bit_inc_i,
  input  wire                         out_ld_bus_i,
  input  wire                         out_ld_ireg_i,
  input  wire                         out_shift_i,
  input  wire                         crc_clr_i,
  input  wire                         crc_en_i,
  input  wire                         crc_in_tdi_i,
  input  wire                         crc_shift_i,
  input  wire                         regsel_ld_i,
  input  wire                         ireg_wr_i,
  input  wire                         err_check_i,
  input  wire                         biu_strobe_i,
  input  wire dbg_pkg::tdo_sel_e      tdo_sel_i,
  input  wire  [`DBG_DATA_WIDTH-1:0]  biu_data_i,
  input  wire                         biu_ready_i,
  input  wire                         biu_err_i,
  output wire  [`DBG_ADDR_WIDTH-1:0]  addr_o,
  output wire  [`DBG_DATA_WIDTH-1:0]  wdata_o,
  output wire                         word_count_zero_o,
  output wire                         last_word_o,
  output wire                         bit_count_last_o,
  output wire                         bit_count_32_o,
  output logic                        module_tdo_o
);

  logic [`DBG_ADDR_WIDTH-1:0]  addr_q;
  logic [`DBG_COUNT_WIDTH-1:0] word_q;     // Words left
  logic [5:0]                  bit_q;
  logic [`DBG_DATA_WIDTH:0]    out_q;      // 33 bits, fits the error register
  logic [`DBG_ADDR_WIDTH:0]    err_q;      // {address, error bit}
  logic                        regsel_q;
  logic [`DBG_ADDR_WIDTH:0]    ireg_data;
  logic [31:0]                 crc;
  logic                        crc_serial;
  logic                        crc_match;

  //////////////////////////////
  // Counters
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
    end else begin
      if (addr_ld_i) addr_q <= dr_i[`DBG_ADDR_MSB -: `DBG_ADDR_WIDTH];
      else if (addr_inc_i) addr_q <= addr_q + `DBG_WORD_BYTES;
      if (word_ld_i) word_q <= dr_i[`DBG_COUNT_WIDTH-1:0];
      else if (word_dec_i) word_q <= word_q - 1'b1;
      if (bit_clr_i) bit_q <= '0;   // Clear wins at a word boundary
      else if (bit_inc_i) bit_q <= bit_q + 6'd1;
    end
  end

  assign word_count_zero_o = (word_q == '0);
  assign last_word_o       = (word_q == `DBG_COUNT_WIDTH'(1));
  assign bit_count_last_o  = (bit_q == 6'd31);
  assign bit_count_32_o    = (bit_q == 6'd32);
  assign addr_o            = addr_q;
  // Last write bit is still on tdi, the other 31 sit at the top of the DR
  assign wdata_o = {tdi_i, dr_i[`DBG_DR_WIDTH-1 -: `DBG_DATA_WIDTH-1]};

  //////////////////////////////
  // Internal registers
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      regsel_q <= 1'b0;
    end else if (regsel_ld_i) begin
      regsel_q <= dr_i[`DBG_ADDR_MSB];
    end
  end

  // Error register keeps the address of the first failing access
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      err_q <= '0;
    end else if (ireg_wr_i && !dr_i[`DBG_ADDR_MSB]) begin
      if (dr_i[`DBG_ADDR_MSB-1]) err_q[0] <= 1'b0;   // Write 1 to clear
    end else if (!err_q[0]) begin
      if (err_check_i && (biu_err_i || (biu_strobe_i && !biu_ready_i))) begin
        err_q[0] <= 1'b1;   // Bus error or overrun
      end else if (biu_strobe_i) begin
        err_q[`DBG_ADDR_WIDTH:1] <= addr_q;
      end
    end
  end

  assign ireg_data = regsel_q ? '0 : err_q;

  // Output shifter, LSB goes to tdo
  always_ff @(posedge tck_i) begin
    if (out_ld_bus_i) out_q <= {1'b0, biu_data_i};
    else if (out_ld_ireg_i) out_q <= ireg_data;
    else if (out_shift_i) out_q <= {1'b0, out_q[`DBG_DATA_WIDTH:1]};
  end

  //////////////////////////////
  // CRC and tdo
  dbg_crc32 crc0 (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clr_i    (crc_clr_i),
    .en_i     (crc_en_i),
    .shift_i  (crc_shift_i),
    .bit_i    (crc_in_tdi_i ? tdi_i : out_q[0]),
    .crc_o    (crc),
    .serial_o (crc_serial)
  );

  assign crc_match = (dr_i[`DBG_DR_WIDTH-1 -: 32] == crc);   // Host CRC, bits 52..21

  always_comb begin
    unique case (tdo_sel_i)
      dbg_pkg::tdo_ready: module_tdo_o = biu_ready_i;
      dbg_pkg::tdo_data:  module_tdo_o = out_q[0];
      dbg_pkg::tdo_match: module_tdo_o = crc_match;
      default:            module_tdo_o = crc_serial;
    endcase
  end

endmodule

`default_nettype wire

/* dbg_wb_module.sv */
/*
  Debug unit Wishbone module; the TAP and its 53-bit shift register sit outside.
  32-bit bursts only, Wishbone clocked by tck_i.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_params.svh"

module dbg_wb_module (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  wire                        tdi_i,
  input  wire                        capture_dr_i,
  input  wire                        shift_dr_i,
  input  wire                        update_dr_i,
  input  wire [`DBG_DR_WIDTH-1:0]    data_register_i,
  input  wire                        module_select_i,
  output wire                        module_tdo_o,
  output wire                        top_inhibit_o,
  output wire [`DBG_ADDR_WIDTH-1:0]  wb_adr_o,
  output wire [`DBG_DATA_WIDTH-1:0]  wb_dat_o,
  input  wire [`DBG_DATA_WIDTH-1:0]  wb_dat_i,
  output wire                        wb_cyc_o,
  output wire                        wb_stb_o,
  output wire                        wb_we_o,
  input  wire                        wb_ack_i,
  input  wire                        wb_err_i
);

  // FSM controls
  wire addr_ld, addr_inc, word_ld, word_dec, bit_clr, bit_inc;
  wire out_ld_bus, out_ld_ireg, out_shift;
  wire crc_clr, crc_en, crc_in_tdi, crc_shift;
  wire regsel_ld, ireg_wr, err_check, biu_strobe, biu_clr, biu_rd;
  dbg_pkg::tdo_sel_e tdo_sel;
  // Datapath status
  wire word_count_zero, last_word, bit_count_last, bit_count_32;
  // BIU
  wire [`DBG_ADDR_WIDTH-1:0] biu_addr;
  wire [`DBG_DATA_WIDTH-1:0] biu_wdata, biu_rdata;
  wire biu_ready, biu_err;

  dbg_burst_fsm fsm0 (
    .tck_i (tck_i), .rst_i (rst_i),
    .capture_dr_i (capture_dr_i), .shift_dr_i (shift_dr_i),
    .update_dr_i (update_dr_i), .module_select_i (module_select_i),
    .dr_top_i (data_register_i[`DBG_DR_WIDTH-1]),
    .opcode_i (dbg_pkg::dbg_cmd_e'(data_register_i[`DBG_OP_MSB:`DBG_OP_LSB])),
    .word_count_zero_i (word_count_zero), .last_word_i (last_word),
    .bit_count_last_i (bit_count_last), .bit_count_32_i (bit_count_32),
    .biu_ready_i (biu_ready),
    .addr_ld_o (addr_ld), .addr_inc_o (addr_inc),
    .word_ld_o (word_ld), .word_dec_o (word_dec),
    .bit_clr_o (bit_clr), .bit_inc_o (bit_inc),
    .out_ld_bus_o (out_ld_bus), .out_ld_ireg_o (out_ld_ireg), .out_shift_o (out_shift),
    .crc_clr_o (crc_clr), .crc_en_o (crc_en),
    .crc_in_tdi_o (crc_in_tdi), .crc_shift_o (crc_shift),
    .regsel_ld_o (regsel_ld), .ireg_wr_o (ireg_wr), .err_check_o (err_check),
    .biu_strobe_o (biu_strobe), .biu_clr_o (biu_clr), .burst_rd_o (biu_rd),
    .tdo_sel_o (tdo_sel), .top_inhibit_o (top_inhibit_o)
  );

  dbg_wb_datapath dp0 (
    .tck_i (tck_i), .rst_i (rst_i), .tdi_i (tdi_i), .dr_i (data_register_i),
    .addr_ld_i (addr_ld), .addr_inc_i (addr_inc),
    .word_ld_i (word_ld), .word_dec_i (word_dec),
    .bit_clr_i (bit_clr), .bit_inc_i (bit_inc),
    .out_ld_bus_i (out_ld_bus), .out_ld_ireg_i (out_ld_ireg), .out_shift_i (out_shift),
    .crc_clr_i (crc_clr), .crc_en_i (crc_en),
    .crc_in_tdi_i (crc_in_tdi), .crc_shift_i (crc_shift),
    .regsel_ld_i (regsel_ld), .ireg_wr_i (ireg_wr), .err_check_i (err_check),
    .biu_strobe_i (biu_strobe), .tdo_sel_i (tdo_sel),
    .biu_data_i (biu_rdata), .biu_ready_i (biu_ready), .biu_err_i (biu_err),
    .addr_o (biu_addr), .wdata_o (biu_wdata),
    .word_count_zero_o (word_count_zero), .last_word_o (last_word),
    .bit_count_last_o (bit_count_last), .bit_count_32_o (bit_count_32),
    .module_tdo_o (module_tdo_o)
  );

  dbg_wb_biu biu0 (
    .tck_i (tck_i), .rst_i (rst_i), .clr_i (biu_clr), .strobe_i (biu_strobe),
    .rd_i (biu_rd), .addr_i (biu_addr), .data_i (biu_wdata),
    .data_o (biu_rdata), .rdy_o (biu_ready), .err_o (biu_err),
    .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o), .wb_dat_i (wb_dat_i),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o),
    .wb_ack_i (wb_ack_i), .wb_err_i (wb_err_i)
  );

endmodule

`default_nettype wire

/* tb_dbg_wb.sv */
/*
  Directed testbench for the Wishbone debug module.
  The TAP data register and a 256-word Wishbone slave are modelled here.
  One address is poisoned and always answers with err.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_params.svh"

module tb_dbg_wb;

  localparam logic [31:0] POISON_ADDR = 32'h0000_0200;
  localparam int RESET_CYCLES = 16;
  // Rough length of each test in clock cycles
  localparam int TEST_CYCLES  = 120 + 260 + 260 + 280 + 520;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * 4 * 2;   // 2x margin

  logic        tck_i = 1'b0;
  logic        rst_i = 1'b1;
  logic        tdi = 1'b0;
  logic        cap_dr = 1'b0;
  logic        shf_dr = 1'b0;
  logic        upd_dr = 1'b0;
  logic [52:0] tap_dr = '0;     // TAP data register model
  logic        module_tdo_o;
  logic        top_inhibit_o;
  logic [31:0] wb_adr_o, wb_dat_o;
  logic [31:0] wb_dat_in = '0;
  logic        wb_cyc_o, wb_stb_o, wb_we_o;
  logic        wb_ack = 1'b0;
  logic        wb_err = 1'b0;

  logic [31:0] mem [0:255];     // Slave memory
  logic [31:0] wr_words [0:3];  // Burst payload
  logic        slave_busy = 1'b0;
  int          slave_wait = 0;

  dbg_wb_module dut0 (
    .tck_i (tck_i), .rst_i (rst_i), .tdi_i (tdi),
    .capture_dr_i (cap_dr), .shift_dr_i (shf_dr), .update_dr_i (upd_dr),
    .data_register_i (tap_dr), .module_select_i (1'b1),
    .module_tdo_o (module_tdo_o), .top_inhibit_o (top_inhibit_o),
    .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o), .wb_dat_i (wb_dat_in),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o),
    .wb_ack_i (wb_ack), .wb_err_i (wb_err)
  );

  always #2 tck_i = ~tck_i;   // 4 ns period

  //////////////////////////////
  // Wishbone slave, 0 to 3 wait states
  always begin
    @(posedge tck_i);
    #1;
    if (wb_ack || wb_err) begin
      wb_ack     = 1'b0;   // Cycle closed on this edge
      wb_err     = 1'b0;
      slave_busy = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!slave_busy) begin
        slave_busy = 1'b1;
        slave_wait = $urandom % 4;
      end
      if (slave_wait > 0) begin
        slave_wait = slave_wait - 1;
      end else if (wb_adr_o == POISON_ADDR) begin
        wb_err = 1'b1;
      end else begin
        wb_ack = 1'b1;
        if (wb_we_o) mem[wb_adr_o[9:2]] = wb_dat_o;
        else wb_dat_in = mem[wb_adr_o[9:2]];
      end
    end
  end

  initial begin
    #WATCHDOG_NS;
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $fatal(1);
  end

  //////////////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s got=%h expected=%h", name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Serial CRC-32 step, reflected polynomial, LSB first
  function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic b);
    logic fb;
    fb = crc[0] ^ b;
    crc_next = (crc >> 1) ^ (fb ? `DBG_CRC_POLY : 32'h0);
  endfunction

  // One TCK cycle of the TAP; tdo is taken on the falling edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd,
                           input logic tdi_bit, output logic tdo_bit);
    cap_dr = cap;
    shf_dr = sh;
    upd_dr = upd;
    tdi    = tdi_bit;
    @(negedge tck_i);
    tdo_bit = module_tdo_o;
    @(posedge tck_i);
    #1;
    if (cap) tap_dr = '0;
    else if (sh) tap_dr = {tdi_bit, tap_dr[52:1]};
    cap_dr = 1'b0;
    shf_dr = 1'b0;
    upd_dr = 1'b0;
    tdi    = 1'b0;
  endtask

  task automatic shift_dr(input logic [63:0] bits_in, input int nbits,
                          output logic [63:0] bits_out);
    logic t;
    bits_out = '0;
    for (int i = 0; i < nbits; i++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, bits_in[i], t);   // LSB first
      bits_out[i] = t;
    end
  endtask

  // Capture, shift the 53-bit command in, update
  task automatic send_command(input logic [3:0] op, input logic [31:0] addr,
                              input logic [15:0] count);
    logic        t;
    logic [63:0] dummy;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    shift_dr({11'h0, 1'b0, op, addr, count}, 53, dummy);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);   // Let rbegin / wready settle
  endtask

  task automatic read_error_reg(output logic [32:0] value);
    logic        t;
    logic [63:0] bits;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    shift_dr('0, 33, bits);
    value = bits[32:0];
  endtask

  task automatic burst_write(input logic [31:0] base, input logic [15:0] n,
                             input logic bad_crc, output logic match);
    logic        t;
    logic [31:0] crc;
    logic [63:0] dummy;
    crc = `DBG_CRC_INIT;
    send_command(`DBG_CMD_BWRITE32, base, n);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    check_value("top_inhibit_o", 64'(top_inhibit_o), 64'h1);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);   // Start bit
    for (int i = 0; i < n; i++) begin
      shift_dr({32'h0, wr_words[i]}, 32, dummy);
      for (int b = 0; b < 32; b++) crc = crc_next(crc, wr_words[i][b]);
    end
    if (bad_crc) crc[5] = ~crc[5];
    shift_dr({32'h0, crc}, 32, dummy);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, match);   // Match bit on tdo
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  //////////////////////////////
  // Tests
  task automatic reset_state_check;
    logic [32:0] ereg;
    check_value("wb_cyc_o", 64'(wb_cyc_o), 64'h0);
    check_value("wb_stb_o", 64'(wb_stb_o), 64'h0);
    check_value("wb_we_o", 64'(wb_we_o), 64'h0);
    check_value("top_inhibit_o", 64'(top_inhibit_o), 64'h0);
    send_command(`DBG_CMD_IREG_SEL, 32'h0, 16'h0);
    read_error_reg(ereg);
    check_value("error_reg", 64'(ereg), 64'h0);
  endtask

  task automatic write_crc_check(input logic bad_crc);
    logic match;
    for (int i = 0; i < 4; i++) wr_words[i] = $urandom;
    burst_write(32'h0000_0100, 16'd4, bad_crc, match);
    for (int i = 0; i < 4; i++) begin
      check_value("mem", 64'(mem[8'h40 + i]), 64'(wr_words[i]));
    end
    check_value("crc_match", 64'(match), bad_crc ? 64'h0 : 64'h1);
  endtask

  task automatic read_burst_check;
    logic        t;
    logic        ready;
    logic [31:0] crc;
    logic [63:0] bits;
    crc   = `DBG_CRC_INIT;
    ready = 1'b0;
    for (int i = 0; i < 4; i++) mem[8'h10 + i] = $urandom;
    send_command(`DBG_CMD_BREAD32, 32'h0000_0040, 16'd4);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    for (int k = 0; k < 40 && !ready; k++) begin
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);   // Poll status
      ready = t;
    end
    assert (ready) else begin
      $display("read status bit never went high");
      $display("sim failed");
      $fatal(1);
    end
    for (int i = 0; i < 4; i++) begin
      shift_dr('0, 32, bits);
      check_value("read_data", bits, 64'(mem[8'h10 + i]));
      for (int b = 0; b < 32; b++) crc = crc_next(crc, mem[8'h10 + i][b]);
    end
    shift_dr('0, 32, bits);
    check_value("read_crc", bits, 64'(crc));
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic bus_error_check;
    logic        match;
    logic [32:0] ereg;
    wr_words[0] = $urandom;
    wr_words[1] = $urandom;
    burst_write(POISON_ADDR - 32'd4, 16'd2, 1'b0, match);   // Second word is poisoned
    send_command(`DBG_CMD_IREG_SEL, 32'h0, 16'h0);
    read_error_reg(ereg);
    check_value("error_bit", 64'(ereg[0]), 64'h1);
    check_value("error_addr", 64'(ereg[32:1]), 64'(POISON_ADDR));
    send_command(`DBG_CMD_IREG_WR, 32'h4000_0000, 16'h0);   // Bit 46 clears
    read_error_reg(ereg);
    check_value("error_bit", 64'(ereg[0]), 64'h0);
  endtask

  initial begin
    void'($urandom(32'ha6465291));
    for (int i = 0; i < 256; i++) mem[i] = 32'h5a00_0000 ^ (i * 32'h0101_0101);
    repeat (RESET_CYCLES) @(posedge tck_i);
    #1;
    rst_i = 1'b0;
    reset_state_check();
    write_crc_check(1'b0);
    write_crc_check(1'b1);
    read_burst_check();
    bus_error_check();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
dbg_pkg.sv
dbg_crc32.sv
dbg_wb_biu.sv
dbg_burst_fsm.sv
dbg_wb_datapath.sv
dbg_wb_module.sv
tb_dbg_wb.sv

/* run.sh */
#!/bin/sh
# Build and run the debug module testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_dbg_wb -f list.f
out=$(./obj_dir/Vtb_dbg_wb 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "^sim passed$"
